// ==== build.f ====
+incdir+hw
hw/rv32_pkg.sv
hw/control_unit.sv
hw/reg_file.sv
hw/alu.sv
hw/branch_resolver.sv
hw/rv32_exec_core.sv
test/rv32_exec_core_asserts.sv
test/rv32_exec_core_tb.sv

// ==== test/rv32_exec_core_tb.sv ====
// Testbench for the RV32I execute slice
// Seeded random instructions checked against a reference model
// Register init, ALU, immediates, control flow, illegal, dependencies, halt
`timescale 1ns/10ps
`include "rv32_defines.svh"

module rv32_exec_core_tb;

  localparam int retire_timeout = 8;

  logic                clk_i;
  logic                arst_n_i;
  logic                instr_valid_i;
  rv32_pkg::word_t     instr_i;
  rv32_pkg::word_t     pc_i;
  logic                retire_o, wb_we_o, redirect_o, illegal_o, halted_o;
  rv32_pkg::reg_addr_t wb_rd_o;
  rv32_pkg::word_t     wb_data_o, redirect_pc_o;

  integer          seed = 32'h61582b9b;
  int              errors = 0;
  int              checks = 0;
  int              test_err = 0;
  rv32_pkg::word_t model_regs [32];
  // Expected results of the instruction in flight
  logic            exp_we, exp_redirect, exp_illegal, exp_halt;
  rv32_pkg::word_t exp_data, exp_target;

  rv32_exec_core dut (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .retire_o      (retire_o),
    .wb_we_o       (wb_we_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o),
    .illegal_o     (illegal_o),
    .halted_o      (halted_o)
  );

  bind rv32_exec_core rv32_exec_core_asserts u_asserts (
    .clk_i (clk_i), .arst_n_i (arst_n_i), .retire_o (retire_o), .wb_we_o (wb_we_o),
    .wb_rd_o (wb_rd_o), .wb_data_o (wb_data_o), .redirect_o (redirect_o),
    .redirect_pc_o (redirect_pc_o), .illegal_o (illegal_o), .halted_o (halted_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Overall guard against a stuck run
  initial begin
    #100000;
    $display("ERROR: simulation did not finish in time");
    $display("Test failed");
    $finish;
  end

  task automatic check_word(input string name, input rv32_pkg::word_t got,
                            input rv32_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input rv32_pkg::reg_addr_t got,
                            input rv32_pkg::reg_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  function automatic rv32_pkg::word_t rand_word();
    return $random(seed);
  endfunction

  function automatic rv32_pkg::reg_addr_t rand_reg();
    return rv32_pkg::reg_addr_t'($random(seed));
  endfunction

  // Never x0
  function automatic rv32_pkg::reg_addr_t rand_dest();
    return rv32_pkg::reg_addr_t'(($unsigned($random(seed)) % 31) + 1);
  endfunction

  function automatic rv32_pkg::word_t rand_pc();
    return rand_word() & ~32'h3;
  endfunction

  // Instruction encoders
  function automatic rv32_pkg::word_t rtype_word(logic [6:0] f7, rv32_pkg::funct3_t f3,
      rv32_pkg::reg_addr_t rd, rv32_pkg::reg_addr_t rs1, rv32_pkg::reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, rv32_pkg::REGREG};
  endfunction

  function automatic rv32_pkg::word_t itype_word(rv32_pkg::opcode_t opc,
      rv32_pkg::funct3_t f3, rv32_pkg::reg_addr_t rd, rv32_pkg::reg_addr_t rs1,
      logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv32_pkg::word_t btype_word(rv32_pkg::funct3_t f3,
      rv32_pkg::reg_addr_t rs1, rv32_pkg::reg_addr_t rs2, rv32_pkg::word_t imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv32_pkg::BRANCH};
  endfunction

  function automatic rv32_pkg::word_t utype_word(rv32_pkg::opcode_t opc,
      rv32_pkg::reg_addr_t rd, rv32_pkg::word_t imm);
    return {imm[31:12], rd, opc};
  endfunction

  function automatic rv32_pkg::word_t jtype_word(rv32_pkg::reg_addr_t rd,
      rv32_pkg::word_t imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv32_pkg::JAL};
  endfunction

  function automatic logic known_opcode(rv32_pkg::opcode_t opc);
    case (opc)
      rv32_pkg::LUI, rv32_pkg::AUIPC, rv32_pkg::JAL, rv32_pkg::JALR, rv32_pkg::BRANCH,
      rv32_pkg::LOAD, rv32_pkg::STORE, rv32_pkg::IMMED, rv32_pkg::REGREG,
      rv32_pkg::MISCMEM, rv32_pkg::SYSTEM : return 1'b1;
      default : return 1'b0;
    endcase
  endfunction

  // Reference arithmetic, alt selects SUB or SRA
  function automatic rv32_pkg::word_t alu_ref(rv32_pkg::funct3_t f3, logic alt,
      rv32_pkg::word_t x, rv32_pkg::word_t y);
    rv32_pkg::word_t r;
    case (f3)
      rv32_pkg::ADDSUB : r = alt ? (x - y) : (x + y);
      rv32_pkg::SLL    : r = x << y[4:0];
      rv32_pkg::SLT    : r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      rv32_pkg::SLTU   : r = (x < y) ? 32'd1 : 32'd0;
      rv32_pkg::XOR    : r = x ^ y;
      rv32_pkg::OR     : r = x | y;
      rv32_pkg::AND    : r = x & y;
      default : begin
        if (alt) r = $signed(x) >>> y[4:0];
        else     r = x >> y[4:0];
      end
    endcase
    return r;
  endfunction

  task automatic model_exec(input rv32_pkg::word_t instr, input rv32_pkg::word_t pc);
    rv32_pkg::funct3_t f3;
    rv32_pkg::word_t   a, b, imm_i, imm_b, imm_u, imm_j;
    logic              wen;
    f3    = instr[14:12];
    a     = model_regs[instr[19:15]];
    b     = model_regs[instr[24:20]];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_u = {instr[31:12], 12'b0};
    imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    wen = 1'b0;
    exp_redirect = 1'b0;
    exp_illegal = 1'b0;
    exp_data = '0;
    exp_target = '0;
    case (instr[6:0])
      rv32_pkg::LUI : begin
        wen = 1'b1;
        exp_data = imm_u;
      end
      rv32_pkg::AUIPC : begin
        wen = 1'b1;
        exp_data = pc + imm_u;
      end
      rv32_pkg::JAL, rv32_pkg::JALR : begin
        wen = 1'b1;
        exp_data = pc + 32'd4;
        exp_redirect = 1'b1;
        if (instr[6:0] == rv32_pkg::JAL) exp_target = pc + imm_j;
        else                             exp_target = (a + imm_i) & ~32'h1;
      end
      rv32_pkg::BRANCH : begin
        exp_target = pc + imm_b;
        case (f3)
          rv32_pkg::BEQ  : exp_redirect = (a == b);
          rv32_pkg::BNE  : exp_redirect = (a != b);
          rv32_pkg::BLT  : exp_redirect = ($signed(a) < $signed(b));
          rv32_pkg::BGE  : exp_redirect = ($signed(a) >= $signed(b));
          rv32_pkg::BLTU : exp_redirect = (a < b);
          rv32_pkg::BGEU : exp_redirect = (a >= b);
          default        : exp_redirect = 1'b0;
        endcase
      end
      rv32_pkg::IMMED : begin
        wen = 1'b1;
        exp_data = alu_ref(f3, (f3 == rv32_pkg::SR) && instr[30], a, imm_i);
      end
      rv32_pkg::REGREG : begin
        if (instr[31:25] == 7'h00 || instr[31:25] == 7'h20) begin
          wen = 1'b1;
          exp_data = alu_ref(f3, instr[30], a, b);
        end else begin
          exp_illegal = 1'b1;
        end
      end
      rv32_pkg::LOAD, rv32_pkg::STORE, rv32_pkg::MISCMEM, rv32_pkg::SYSTEM : ;
      default : exp_illegal = 1'b1;
    endcase
    exp_we   = wen && (instr[11:7] != 5'd0);
    exp_halt = (`INFINITE_LOOP_HALTS != 0) && (instr == 32'h0000006f);
  endtask

  // Starts on a falling edge and returns on the falling edge of the result
  task automatic run_instr(input rv32_pkg::word_t instr, input rv32_pkg::word_t pc);
    int waited;
    model_exec(instr, pc);
    instr_valid_i = 1'b1;
    instr_i = instr;
    pc_i = pc;
    waited = 0;
    do begin
      @(negedge clk_i);
      instr_valid_i = 1'b0;
      waited++;
    end while (!retire_o && waited < retire_timeout);
    if (!retire_o) begin
      errors++;
      $display("ERROR: instruction %h at pc %h never retired", instr, pc);
    end else begin
      check_flag("illegal_o", illegal_o, exp_illegal);
      check_flag("wb_we_o", wb_we_o, exp_we);
      check_addr("wb_rd_o", wb_rd_o, instr[11:7]);
      if (exp_we) check_word("wb_data_o", wb_data_o, exp_data);
      check_flag("redirect_o", redirect_o, exp_redirect);
      if (exp_redirect) check_word("redirect_pc_o", redirect_pc_o, exp_target);
      check_flag("halted_o", halted_o, exp_halt);
      if (exp_we) model_regs[instr[11:7]] = exp_data;
    end
  endtask

  task automatic expect_no_retire(input rv32_pkg::word_t instr);
    int waited;
    instr_valid_i = 1'b1;
    instr_i = instr;
    waited = 0;
    do begin
      @(negedge clk_i);
      instr_valid_i = 1'b0;
      waited++;
    end while (!retire_o && waited < retire_timeout);
    checks++;
    if (retire_o) begin
      errors++;
      $display("ERROR: instruction %h retired while halted", instr);
    end
    check_flag("halted_o", halted_o, 1'b1);
  endtask

  task automatic report_test(input string name);
    $display("%s done: %0d errors", name, errors - test_err);
    test_err = errors;
  endtask

  initial begin
    rv32_pkg::word_t     w;
    rv32_pkg::word_t     instr;
    rv32_pkg::funct3_t   f3;
    rv32_pkg::funct3_t   br_types [6];
    rv32_pkg::reg_addr_t rd, rs1;
    logic [11:0]         imm12;
    arst_n_i = 1'b0;
    instr_valid_i = 1'b0;
    instr_i = '0;
    pc_i = '0;
    br_types = '{rv32_pkg::BEQ, rv32_pkg::BNE, rv32_pkg::BLT, rv32_pkg::BGE,
                 rv32_pkg::BLTU, rv32_pkg::BGEU};
    for (int r = 0; r < 32; r++) model_regs[r] = '0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    for (int r = 1; r < 32; r++) begin
      run_instr(utype_word(rv32_pkg::LUI, 5'(r), rand_word()), rand_pc());
      w = rand_word();
      run_instr(itype_word(rv32_pkg::IMMED, rv32_pkg::ADDSUB, 5'(r), 5'(r), w[11:0]), rand_pc());
    end
    report_test("register init");

    for (int i = 0; i < 80; i++) begin
      w = rand_word();
      instr = rtype_word(w[0] ? 7'h20 : 7'h00, rv32_pkg::funct3_t'(i), rand_reg(), rand_reg(),
                         rand_reg());
      run_instr(instr, rand_pc());
    end
    report_test("register-register ALU");

    for (int i = 0; i < 60; i++) begin
      w = rand_word();
      f3 = w[2:0];
      imm12 = w[19:8];
      if (f3 == rv32_pkg::SLL) imm12 = {7'h00, w[24:20]};
      if (f3 == rv32_pkg::SR) imm12 = {w[25] ? 7'h20 : 7'h00, w[24:20]};
      run_instr(itype_word(rv32_pkg::IMMED, f3, rand_reg(), rand_reg(), imm12), rand_pc());
    end
    for (int i = 0; i < 20; i++) begin
      w = rand_word();
      instr = utype_word(w[0] ? rv32_pkg::LUI : rv32_pkg::AUIPC, rand_reg(), rand_word());
      run_instr(instr, rand_pc());
    end
    report_test("immediate, LUI and AUIPC");

    for (int i = 0; i < 60; i++) begin
      w = rand_word();
      rs1 = rand_reg();
      run_instr(btype_word(br_types[i % 6], rs1, w[3] ? rs1 : rand_reg(), rand_word()),
                rand_pc());
    end
    for (int i = 0; i < 20; i++) begin
      instr = jtype_word(rand_reg(), rand_word());
      // Keep the halt encoding out of this test
      if (instr == 32'h0000006f) instr[11:7] = 5'd1;
      run_instr(instr, rand_pc());
      w = rand_word();
      run_instr(itype_word(rv32_pkg::JALR, 3'b000, rand_reg(), rand_reg(), w[11:0]), rand_pc());
    end
    report_test("branch and jump");

    for (int i = 0; i < 20; i++) begin
      do begin
        w = rand_word();
      end while (known_opcode(w[6:0]));
      run_instr(w, rand_pc());
      run_instr(rtype_word(7'h00, rv32_pkg::ADDSUB, rand_dest(), w[11:7], 5'd0), rand_pc());
      do begin
        w = rand_word();
      end while (w[31:25] == 7'h00 || w[31:25] == 7'h20);
      run_instr({w[31:7], rv32_pkg::REGREG}, rand_pc());
      run_instr(rtype_word(7'h00, rv32_pkg::ADDSUB, rand_dest(), w[11:7], 5'd0), rand_pc());
    end
    report_test("illegal instruction");

    rd = rand_dest();
    for (int i = 0; i < 30; i++) begin
      rs1 = rd;
      rd = rand_dest();
      w = rand_word();
      if (w[0]) instr = itype_word(rv32_pkg::IMMED, rv32_pkg::ADDSUB, rd, rs1, w[31:20]);
      else      instr = rtype_word(7'h00, rv32_pkg::ADDSUB, rd, rs1, rs1);
      run_instr(instr, rand_pc());
    end
    for (int i = 0; i < 10; i++) begin
      w = rand_word();
      run_instr(itype_word(rv32_pkg::IMMED, rv32_pkg::XOR, 5'd0, rand_dest(), w[11:0]),
                rand_pc());
      run_instr(rtype_word(7'h00, rv32_pkg::OR, rand_dest(), 5'd0, 5'd0), rand_pc());
    end
    report_test("dependencies and x0");

    if (`INFINITE_LOOP_HALTS != 0) begin
      run_instr(32'h0000006f, rand_pc());
      for (int i = 0; i < 5; i++) begin
        expect_no_retire(rtype_word(7'h00, rv32_pkg::ADDSUB, rand_dest(), rand_reg(),
                                    rand_reg()));
      end
    end
    report_test("halt");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== test/rv32_exec_core_asserts.sv ====
// Concurrent checks on the execute slice outputs
// Bound into rv32_exec_core from the testbench
`timescale 1ns/10ps

module rv32_exec_core_asserts (
  input logic                clk_i,
  input logic                arst_n_i,
  input logic                retire_o,
  input logic                wb_we_o,
  input rv32_pkg::reg_addr_t wb_rd_o,
  input rv32_pkg::word_t     wb_data_o,
  input logic                redirect_o,
  input rv32_pkg::word_t     redirect_pc_o,
  input logic                illegal_o,
  input logic                halted_o
);

  // Every reported effect belongs to a retired instruction
  a_effect_retire : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (wb_we_o || redirect_o || illegal_o) |-> retire_o)
    else $error("write, redirect or illegal flag seen without retire_o");

  // Sticky halt
  a_halt_sticky : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    halted_o |=> halted_o)
    else $error("halted_o fell without a reset");

  // x0 is never a reported write target
  a_x0_write : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_we_o |-> (wb_rd_o != '0))
    else $error("register write reported to x0");

  a_known : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$isunknown({retire_o, wb_we_o, wb_rd_o, wb_data_o, redirect_o, redirect_pc_o,
                 illegal_o, halted_o}))
    else $error("unknown value on a result output");

endmodule

// ==== hw/rv32_exec_core.sv ====
// RV32I execute slice top level
// Decoder, register file, ALU and branch unit
// Writeback mux, sticky halt flag and registered result outputs
`timescale 1ns/10ps

module rv32_exec_core (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                instr_valid_i,
  input  rv32_pkg::word_t     instr_i,
  input  rv32_pkg::word_t     pc_i,
  output logic                retire_o,
  output logic                wb_we_o,
  output rv32_pkg::reg_addr_t wb_rd_o,
  output rv32_pkg::word_t     wb_data_o,
  output logic                redirect_o,
  output rv32_pkg::word_t     redirect_pc_o,
  output logic                illegal_o,
  output logic                halted_o
);

  rv32_pkg::reg_addr_t rs1, rs2, rd;
  rv32_pkg::word_t     imm, rdata1, rdata2, alu_result, target, link_pc, wb_data;
  rv32_pkg::alu_op_t   alu_op;
  rv32_pkg::w_src_t    w_src;
  rv32_pkg::funct3_t   branch_type;
  logic                alu_a_pc, alu_b_imm, wen, branch, jump, j_sel;
  logic                illegal, halt, redirect, accept, rf_we;

  control_unit u_control_unit (
    .instr_i       (instr_i),
    .reg_rs1_o     (rs1),
    .reg_rs2_o     (rs2),
    .reg_rd_o      (rd),
    .imm_o         (imm),
    .alu_a_pc_o    (alu_a_pc),
    .alu_b_imm_o   (alu_b_imm),
    .alu_op_o      (alu_op),
    .w_src_o       (w_src),
    .wen_o         (wen),
    .branch_o      (branch),
    .jump_o        (jump),
    .j_sel_o       (j_sel),
    .branch_type_o (branch_type),
    .illegal_o     (illegal),
    .halt_o        (halt)
  );

  reg_file u_reg_file (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .rs1_i     (rs1),
    .rs2_i     (rs2),
    .wr_addr_i (rd),
    .we_i      (rf_we),
    .wdata_i   (wb_data),
    .rdata1_o  (rdata1),
    .rdata2_o  (rdata2)
  );

  alu u_alu (
    .alu_op_i    (alu_op),
    .alu_a_pc_i  (alu_a_pc),
    .alu_b_imm_i (alu_b_imm),
    .rs1_data_i  (rdata1),
    .rs2_data_i  (rdata2),
    .pc_i        (pc_i),
    .imm_i       (imm),
    .result_o    (alu_result)
  );

  branch_resolver u_branch_resolver (
    .branch_i      (branch),
    .jump_i        (jump),
    .j_sel_i       (j_sel),
    .branch_type_i (branch_type),
    .rs1_data_i    (rdata1),
    .rs2_data_i    (rdata2),
    .pc_i          (pc_i),
    .imm_i         (imm),
    .redirect_o    (redirect),
    .target_o      (target)
  );

  // Nothing is accepted once halted
  assign accept  = instr_valid_i && !halted_o;
  assign rf_we   = accept && wen && !illegal;
  assign link_pc = pc_i + rv32_pkg::word_t'(4);
  assign wb_data = (w_src == rv32_pkg::WB_LINK) ? link_pc : alu_result;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      retire_o      <= 1'b0;
      wb_we_o       <= 1'b0;
      wb_rd_o       <= '0;
      wb_data_o     <= '0;
      redirect_o    <= 1'b0;
      redirect_pc_o <= '0;
      illegal_o     <= 1'b0;
      halted_o      <= 1'b0;
    end else begin
      retire_o   <= accept;
      // Writes to x0 are dropped by the register file, so not reported
      wb_we_o    <= rf_we && (rd != '0);
      redirect_o <= accept && redirect && !illegal;
      illegal_o  <= accept && illegal;
      // Sticky until reset
      halted_o   <= halted_o || (accept && halt);
      if (accept) begin
        wb_rd_o       <= rd;
        wb_data_o     <= wb_data;
        redirect_pc_o <= target;
      end
    end
  end

endmodule

// ==== hw/branch_resolver.sv ====
// Branch condition evaluation and control transfer target
// Conditional branches, JAL and JALR
`timescale 1ns/10ps

module branch_resolver (
  input  logic              branch_i,
  input  logic              jump_i,
  input  logic              j_sel_i,
  input  rv32_pkg::funct3_t branch_type_i,
  input  rv32_pkg::word_t   rs1_data_i,
  input  rv32_pkg::word_t   rs2_data_i,
  input  rv32_pkg::word_t   pc_i,
  input  rv32_pkg::word_t   imm_i,
  output logic              redirect_o,
  output rv32_pkg::word_t   target_o
);

  logic            taken;
  rv32_pkg::word_t jalr_target;

  always_comb begin
    case (branch_type_i)
      rv32_pkg::BEQ  : taken = (rs1_data_i == rs2_data_i);
      rv32_pkg::BNE  : taken = (rs1_data_i != rs2_data_i);
      rv32_pkg::BLT  : taken = ($signed(rs1_data_i) < $signed(rs2_data_i));
      rv32_pkg::BGE  : taken = ($signed(rs1_data_i) >= $signed(rs2_data_i));
      rv32_pkg::BLTU : taken = (rs1_data_i < rs2_data_i);
      rv32_pkg::BGEU : taken = (rs1_data_i >= rs2_data_i);
      default        : taken = 1'b0;
    endcase
  end

  // JALR clears bit 0 of the sum
  assign jalr_target = (rs1_data_i + imm_i) & ~rv32_pkg::word_t'(1);

  assign target_o   = (jump_i && !j_sel_i) ? jalr_target : pc_i + imm_i;
  assign redirect_o = jump_i || (branch_i && taken);

endmodule

// ==== hw/alu.sv ====
// Integer ALU with operand multiplexers
// A is rs1 or pc, B is rs2 or the immediate
`timescale 1ns/10ps

module alu (
  input  rv32_pkg::alu_op_t alu_op_i,
  input  logic              alu_a_pc_i,
  input  logic              alu_b_imm_i,
  input  rv32_pkg::word_t   rs1_data_i,
  input  rv32_pkg::word_t   rs2_data_i,
  input  rv32_pkg::word_t   pc_i,
  input  rv32_pkg::word_t   imm_i,
  output rv32_pkg::word_t   result_o
);

  rv32_pkg::word_t op_a;
  rv32_pkg::word_t op_b;
  logic [4:0]      shamt;

  assign op_a  = alu_a_pc_i  ? pc_i  : rs1_data_i;
  assign op_b  = alu_b_imm_i ? imm_i : rs2_data_i;

  // Shift amount from the low bits of B, also covers shamt of shift-immediates
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op_i)
      rv32_pkg::ALU_ADD  : result_o = op_a + op_b;
      rv32_pkg::ALU_SUB  : result_o = op_a - op_b;
      rv32_pkg::ALU_SLL  : result_o = op_a << shamt;
      rv32_pkg::ALU_SRL  : result_o = op_a >> shamt;
      rv32_pkg::ALU_SRA  : result_o = rv32_pkg::word_t'($signed(op_a) >>> shamt);
      rv32_pkg::ALU_AND  : result_o = op_a & op_b;
      rv32_pkg::ALU_OR   : result_o = op_a | op_b;
      rv32_pkg::ALU_XOR  : result_o = op_a ^ op_b;
      // Compares give 1 or 0
      rv32_pkg::ALU_SLT  : result_o = rv32_pkg::word_t'($signed(op_a) < $signed(op_b));
      rv32_pkg::ALU_SLTU : result_o = rv32_pkg::word_t'(op_a < op_b);
      default            : result_o = op_a + op_b;
    endcase
  end

endmodule

// ==== hw/reg_file.sv ====
// RV32I integer register file
// Two combinational read ports, one synchronous write port, x0 reads zero
`timescale 1ns/10ps

module reg_file (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  rv32_pkg::reg_addr_t rs1_i,
  input  rv32_pkg::reg_addr_t rs2_i,
  input  rv32_pkg::reg_addr_t wr_addr_i,
  input  logic                we_i,
  input  rv32_pkg::word_t     wdata_i,
  output rv32_pkg::word_t     rdata1_o,
  output rv32_pkg::word_t     rdata2_o
);

  localparam int n_regs = 2 ** $bits(rv32_pkg::reg_addr_t);

  // No storage behind x0
  rv32_pkg::word_t regs [n_regs-1:1];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < n_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (wr_addr_i != '0)) begin
      regs[wr_addr_i] <= wdata_i;
    end
  end

  assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// ==== hw/control_unit.sv ====
// Combinational RV32I decoder
// Register indices, immediate selection, ALU and writeback selects
// Illegal instruction and self-loop halt detection
`timescale 1ns/10ps
`include "rv32_defines.svh"

module control_unit (
  input  rv32_pkg::word_t     instr_i,
  output rv32_pkg::reg_addr_t reg_rs1_o,
  output rv32_pkg::reg_addr_t reg_rs2_o,
  output rv32_pkg::reg_addr_t reg_rd_o,
  output rv32_pkg::word_t     imm_o,
  output logic                alu_a_pc_o,
  output logic                alu_b_imm_o,
  output rv32_pkg::alu_op_t   alu_op_o,
  output rv32_pkg::w_src_t    w_src_o,
  output logic                wen_o,
  output logic                branch_o,
  output logic                jump_o,
  output logic                j_sel_o,
  output rv32_pkg::funct3_t   branch_type_o,
  output logic                illegal_o,
  output logic                halt_o
);

  localparam bit              halt_en    = (`INFINITE_LOOP_HALTS != 0);
  localparam rv32_pkg::word_t halt_instr = 32'h0000006f;

  rv32_pkg::opcode_t opcode;
  rv32_pkg::funct3_t funct3;
  logic [6:0]        funct7;
  rv32_pkg::word_t   imm_itype, imm_stype, imm_sbtype, imm_utype, imm_ujtype;
  logic              is_immed, is_regreg;
  logic              sr, add_sub;
  logic              aluop_sll, aluop_srl, aluop_sra, aluop_add, aluop_sub;
  logic              aluop_and, aluop_or, aluop_xor, aluop_slt, aluop_sltu;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // LUI reads x0 so the ALU adds zero to the U-immediate
  assign reg_rs1_o = (opcode == rv32_pkg::LUI) ? '0 : instr_i[19:15];
  assign reg_rs2_o = instr_i[24:20];
  assign reg_rd_o  = instr_i[11:7];

  // Sign-extended immediates per format
  assign imm_itype  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_stype  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_sbtype = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_utype  = {instr_i[31:12], 12'b0};
  assign imm_ujtype = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};

  always_comb begin
    case (opcode)
      rv32_pkg::STORE              : imm_o = imm_stype;
      rv32_pkg::BRANCH             : imm_o = imm_sbtype;
      rv32_pkg::LUI, rv32_pkg::AUIPC : imm_o = imm_utype;
      rv32_pkg::JAL                : imm_o = imm_ujtype;
      default                      : imm_o = imm_itype;
    endcase
  end

  // Control flow
  assign branch_o      = (opcode == rv32_pkg::BRANCH);
  assign jump_o        = (opcode == rv32_pkg::JAL) || (opcode == rv32_pkg::JALR);
  assign j_sel_o       = (opcode == rv32_pkg::JAL);
  assign branch_type_o = funct3;

  // Operand selects
  assign alu_a_pc_o  = (opcode == rv32_pkg::AUIPC);
  assign alu_b_imm_o = (opcode == rv32_pkg::IMMED) || (opcode == rv32_pkg::LUI) ||
                       (opcode == rv32_pkg::AUIPC);

  assign w_src_o = jump_o ? rv32_pkg::WB_LINK : rv32_pkg::WB_ALU;

  always_comb begin
    case (opcode)
      rv32_pkg::IMMED, rv32_pkg::REGREG,
      rv32_pkg::LUI, rv32_pkg::AUIPC,
      rv32_pkg::JAL, rv32_pkg::JALR : wen_o = 1'b1;
      default                        : wen_o = 1'b0;
    endcase
  end

  // ALU operation flags
  assign is_immed  = (opcode == rv32_pkg::IMMED);
  assign is_regreg = (opcode == rv32_pkg::REGREG);

  assign sr         = (is_immed || is_regreg) && (funct3 == rv32_pkg::SR);
  assign add_sub    = is_regreg && (funct3 == rv32_pkg::ADDSUB);
  assign aluop_sll  = (is_immed || is_regreg) && (funct3 == rv32_pkg::SLL);
  assign aluop_sra  = sr && instr_i[30];
  assign aluop_srl  = sr && !instr_i[30];
  assign aluop_add  = (is_immed && (funct3 == rv32_pkg::ADDSUB)) ||
                      (opcode == rv32_pkg::AUIPC) || (add_sub && !instr_i[30]);
  assign aluop_sub  = add_sub && instr_i[30];
  assign aluop_and  = (is_immed || is_regreg) && (funct3 == rv32_pkg::AND);
  assign aluop_or   = (is_immed || is_regreg) && (funct3 == rv32_pkg::OR);
  assign aluop_xor  = (is_immed || is_regreg) && (funct3 == rv32_pkg::XOR);
  assign aluop_slt  = (is_immed || is_regreg) && (funct3 == rv32_pkg::SLT);
  assign aluop_sltu = (is_immed || is_regreg) && (funct3 == rv32_pkg::SLTU);

  // Priority encode, ADD when nothing matches
  always_comb begin
    if (aluop_sll)       alu_op_o = rv32_pkg::ALU_SLL;
    else if (aluop_sra)  alu_op_o = rv32_pkg::ALU_SRA;
    else if (aluop_srl)  alu_op_o = rv32_pkg::ALU_SRL;
    else if (aluop_add)  alu_op_o = rv32_pkg::ALU_ADD;
    else if (aluop_sub)  alu_op_o = rv32_pkg::ALU_SUB;
    else if (aluop_and)  alu_op_o = rv32_pkg::ALU_AND;
    else if (aluop_or)   alu_op_o = rv32_pkg::ALU_OR;
    else if (aluop_xor)  alu_op_o = rv32_pkg::ALU_XOR;
    else if (aluop_slt)  alu_op_o = rv32_pkg::ALU_SLT;
    else if (aluop_sltu) alu_op_o = rv32_pkg::ALU_SLTU;
    else                 alu_op_o = rv32_pkg::ALU_ADD;
  end

  // Only the base funct7 codes are legal for REGREG
  always_comb begin
    case (opcode)
      rv32_pkg::REGREG : illegal_o = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
      rv32_pkg::LUI, rv32_pkg::AUIPC, rv32_pkg::JAL, rv32_pkg::JALR,
      rv32_pkg::BRANCH, rv32_pkg::LOAD, rv32_pkg::STORE, rv32_pkg::IMMED,
      rv32_pkg::MISCMEM, rv32_pkg::SYSTEM : illegal_o = 1'b0;
      default : illegal_o = 1'b1;
    endcase
  end

  // Jump to self ends the program
  assign halt_o = halt_en && (instr_i == halt_instr);

endmodule

// ==== hw/rv32_pkg.sv ====
// Shared types for the RV32I execute slice
// Word and register index typedefs, opcode and funct3 codes
// ALU operation and writeback source codes
`include "rv32_defines.svh"

package rv32_pkg;

  // Basic vectors
  typedef logic [`XLEN-1:0]       word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [6:0]             opcode_t;
  typedef logic [2:0]             funct3_t;
  typedef logic [3:0]             alu_op_t;
  typedef logic [1:0]             w_src_t;

  // Major opcodes
  localparam opcode_t LUI     = 7'b0110111;
  localparam opcode_t AUIPC   = 7'b0010111;
  localparam opcode_t JAL     = 7'b1101111;
  localparam opcode_t JALR    = 7'b1100111;
  localparam opcode_t BRANCH  = 7'b1100011;
  localparam opcode_t LOAD    = 7'b0000011;
  localparam opcode_t STORE   = 7'b0100011;
  localparam opcode_t IMMED   = 7'b0010011;
  localparam opcode_t REGREG  = 7'b0110011;
  localparam opcode_t MISCMEM = 7'b0001111;
  localparam opcode_t SYSTEM  = 7'b1110011;

  // Arithmetic funct3, shared by IMMED and REGREG
  localparam funct3_t ADDSUB = 3'b000;
  localparam funct3_t SLL    = 3'b001;
  localparam funct3_t SLT    = 3'b010;
  localparam funct3_t SLTU   = 3'b011;
  localparam funct3_t XOR    = 3'b100;
  localparam funct3_t SR     = 3'b101;
  localparam funct3_t OR     = 3'b110;
  localparam funct3_t AND    = 3'b111;

  // Branch funct3
  localparam funct3_t BEQ  = 3'b000;
  localparam funct3_t BNE  = 3'b001;
  localparam funct3_t BLT  = 3'b100;
  localparam funct3_t BGE  = 3'b101;
  localparam funct3_t BLTU = 3'b110;
  localparam funct3_t BGEU = 3'b111;

  // ALU operations
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_SLL  = 4'd2;
  localparam alu_op_t ALU_SRL  = 4'd3;
  localparam alu_op_t ALU_SRA  = 4'd4;
  localparam alu_op_t ALU_AND  = 4'd5;
  localparam alu_op_t ALU_OR   = 4'd6;
  localparam alu_op_t ALU_XOR  = 4'd7;
  localparam alu_op_t ALU_SLT  = 4'd8;
  localparam alu_op_t ALU_SLTU = 4'd9;

  // Writeback sources
  // Link is pc+4 for JAL and JALR
  localparam w_src_t WB_ALU  = 2'd0;
  localparam w_src_t WB_LINK = 2'd1;

endpackage

// ==== hw/rv32_defines.svh ====
// Global sizing macros for the RV32I execute slice
// Data width, register index width and halt option
`ifndef RV32_DEFINES_SVH
`define RV32_DEFINES_SVH

// Data, address and instruction word width
`define XLEN 32

// Register index width, 32 architectural registers
`define REG_ADDR_W 5

// Stop on the "jal x0, 0" self-loop
// 1 enables halt detection, 0 disables it
`define INFINITE_LOOP_HALTS 1

`endif
